// ==== all.f ====
src/mhp_pkg.sv
src/mhp_axil_regs.sv
src/mhp_reset_stretch.sv
src/mhp_dac_serial.sv
src/mhp_dac_sample_pipe.sv
src/mhp_top.sv
verification/tb_mhp_top.sv

// ==== src/mhp_axil_regs.sv ====
/*
  AXI4-Lite register block
  Version, soft reset, DAC enables and serial command launch
*/
`timescale 1ns/1ps
`default_nettype none

module mhp_axil_regs
  import mhp_pkg::*;
#(
  parameter logic [15:0] VER_NUMBER = 16'h00aa
) (
  input  wire                ck933,
  input  wire                rs,
  input  wire axil_req_t     axil_req_i,
  input  wire                spi_busy_i,
  input  wire [7:0]          spi_rdata_i,
  output axil_rsp_t          axil_rsp_o,
  output spi_cmd_t           spi_cmd_o,
  output logic               spi_start_o,
  output logic [NUM_DAC-1:0] dac_en_o,
  output logic               soft_rst_o
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  reg_addr_e          wr_addr;
  reg_addr_e          rd_addr;
  logic               wr_hs;
  logic               rd_hs;
  logic [1:0]         wr_resp;
  logic [1:0]         rd_resp;
  logic [31:0]        rd_word;
  logic               bvalid_q;
  logic               rvalid_q;
  logic [1:0]         bresp_q;
  logic [1:0]         rresp_q;
  logic [31:0]        rdata_q;
  logic [NUM_DAC-1:0] dac_en_q;
  logic               soft_rst_q;

  assign wr_addr = reg_addr_e'(axil_req_i.awaddr);
  assign rd_addr = reg_addr_e'(axil_req_i.araddr);

  // One transaction each way, stalled by a pending response
  assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign rd_hs = axil_req_i.arvalid & ~rvalid_q;

  // **************************************************
  // Address decode
  // **************************************************
  assign wr_resp = (wr_addr inside {REG_RESET, REG_DAC_EN, REG_SPI}) ? RESP_OKAY : RESP_SLVERR;

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (rd_addr)
      REG_VERSION: rd_word = {VER_NUMBER, 16'h0000};
      REG_DAC_EN:  rd_word[NUM_DAC-1:0] = dac_en_q;
      REG_SPI:     rd_word = {spi_busy_i, 23'd0, spi_rdata_i};
      default:     rd_resp = RESP_SLVERR;  // Includes write-only REG_RESET
    endcase
  end

  // Frame request goes straight to the serial master
  assign spi_cmd_o   = spi_cmd_t'(axil_req_i.wdata[$bits(spi_cmd_t)-1:0]);
  assign spi_start_o = wr_hs & (wr_addr == REG_SPI) & ~spi_busy_i;  // Dropped while busy

  // **************************************************
  // Handshake and register state
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      bvalid_q   <= 1'b0;
      bresp_q    <= RESP_OKAY;
      rvalid_q   <= 1'b0;
      rresp_q    <= RESP_OKAY;
      dac_en_q   <= '1;
      soft_rst_q <= 1'b0;
    end else begin
      soft_rst_q <= 1'b0;
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_resp;
        if (wr_addr == REG_DAC_EN && axil_req_i.wstrb[0]) begin
          dac_en_q <= axil_req_i.wdata[NUM_DAC-1:0];
        end
        if (wr_addr == REG_RESET && axil_req_i.wstrb[0]) begin
          soft_rst_q <= axil_req_i.wdata[0];  // One-cycle pulse
        end
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_hs) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_resp;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ck933) begin
    if (rd_hs) begin
      rdata_q <= rd_word;
    end
  end

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready  = wr_hs;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = ~rvalid_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

  assign dac_en_o   = dac_en_q;
  assign soft_rst_o = soft_rst_q;

endmodule

`default_nettype wire

// ==== src/mhp_dac_sample_pipe.sv ====
/*
  DAC sample pipeline
  Two register stages, offset-binary conversion and channel blanking
*/
`timescale 1ns/1ps
`default_nettype none

module mhp_dac_sample_pipe
  import mhp_pkg::*;
(
  input  wire                ck933,
  input  wire                rs,
  input  wire [NUM_DAC-1:0]  dac_en_i,
  input  wire dac_bus_t      data_i,
  output dac_bus_t           data_o
);

  dac_bus_t           s1_data_q;
  logic [NUM_DAC-1:0] s1_en_q;

  // Stage 1 samples travel with the enable seen on entry
  always_ff @(posedge ck933) begin
    s1_data_q <= data_i;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      s1_en_q <= '0;
    end else begin
      s1_en_q <= dac_en_i;
    end
  end

  // Stage 2
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      data_o <= '0;
    end else begin
      for (int i = 0; i < NUM_DAC; i++) begin
        if (s1_en_q[i]) begin
          // Two's complement to offset binary
          data_o[i] <= {~s1_data_q[i][DAC_W-1], s1_data_q[i][DAC_W-2:0]};
        end else begin
          data_o[i] <= '0;  // Channel blanked
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/mhp_dac_serial.sv ====
/*
  Serial control port master for three DACs
  Shared divided clock, one chip select per DAC, 16-bit frames
*/
`timescale 1ns/1ps
`default_nettype none

module mhp_dac_serial
  import mhp_pkg::*;
#(
  parameter int CK_DIV_LOG2 = 2
) (
  input  wire                ck933,
  input  wire                rs,
  input  wire                start_i,
  input  wire spi_cmd_t      cmd_i,
  input  wire                sdi_i,
  output logic               busy_o,
  output logic [7:0]         rdata_o,
  output logic               sclk_o,
  output logic [NUM_DAC-1:0] ncs_o,
  output logic               sdo_o,
  output logic               soe_o
);

  localparam int FRAME_BITS = 16;
  localparam logic [CK_DIV_LOG2-1:0] DIV_RISE = CK_DIV_LOG2'(2 ** (CK_DIV_LOG2 - 1) - 1);

  spi_state_e              state_q;
  logic [CK_DIV_LOG2-1:0]  div_q;
  logic [3:0]              bit_q;
  logic [FRAME_BITS-1:0]   shift_q;
  logic [7:0]              rx_q;
  logic [1:0]              chan_q;
  logic                    rd_q;
  logic                    div_wrap;
  logic                    div_rise;
  logic                    launch;
  logic [NUM_DAC-1:0]      cs_sel;

  assign div_wrap = &div_q;                 // sclk falls here
  assign div_rise = (div_q == DIV_RISE);    // sclk rises here
  assign launch   = (state_q == SPI_IDLE) & start_i & ~busy_o;

  // One-hot chip select, channel 3 selects nothing
  always_comb begin
    cs_sel = '0;
    if (chan_q < NUM_DAC) begin
      cs_sel[chan_q] = 1'b1;
    end
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) div_q <= '0;
    else    div_q <= div_q + 1'b1;
  end

  // **************************************************
  // Frame FSM
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      state_q <= SPI_IDLE;
      bit_q   <= '0;
      busy_o  <= 1'b0;
      sclk_o  <= 1'b1;
      ncs_o   <= '1;
      soe_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          if (launch) begin
            busy_o <= 1'b1;
          end else if (busy_o && div_wrap) begin  // Frame aligned to divider
            state_q <= SPI_SHIFT;
            bit_q   <= '0;
            sclk_o  <= 1'b0;
            ncs_o   <= ~cs_sel;
            soe_o   <= 1'b1;
          end
        end
        SPI_SHIFT: begin
          if (div_rise) begin
            sclk_o <= 1'b1;
          end else if (div_wrap) begin
            if (bit_q == 4'(FRAME_BITS - 1)) begin
              state_q <= SPI_DONE;
              ncs_o   <= '1;
              soe_o   <= 1'b0;
              if (rd_q) rdata_o <= rx_q;
            end else begin
              bit_q  <= bit_q + 1'b1;
              sclk_o <= 1'b0;
              // Turn sdio around after rd and address
              if (bit_q == 4'd7 && rd_q) soe_o <= 1'b0;
            end
          end
        end
        SPI_DONE: begin
          busy_o  <= 1'b0;
          state_q <= SPI_IDLE;
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // Transmit shifter, MSB first
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      shift_q <= '0;
    end else if (launch) begin
      shift_q <= {cmd_i.rd, cmd_i.addr, cmd_i.wdata};
    end else if (state_q == SPI_SHIFT && div_wrap) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge ck933) begin
    if (launch) begin
      chan_q <= cmd_i.chan;
      rd_q   <= cmd_i.rd;
    end
    if (state_q == SPI_SHIFT && div_rise && bit_q[3]) begin
      rx_q <= {rx_q[6:0], sdi_i};  // Data phase bits only
    end
  end

  assign sdo_o = shift_q[FRAME_BITS-1];

endmodule

`default_nettype wire

// ==== src/mhp_pkg.sv ====
/*
  Demodulator interface package
  Widths, register map, serial FSM states and bus structs
*/
`default_nettype none

package mhp_pkg;

  localparam int DAC_W   = 14;  // DAC sample width
  localparam int NUM_DAC = 3;

  // Register byte addresses
  typedef enum logic [3:0] {
    REG_VERSION = 4'h0,
    REG_RESET   = 4'h4,
    REG_DAC_EN  = 4'h8,
    REG_SPI     = 4'hC
  } reg_addr_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_e;

  // Serial frame request, also the REG_SPI write layout in bits 17:0
  typedef struct packed {
    logic [1:0] chan;   // 3 selects no chip
    logic       rd;
    logic [6:0] addr;
    logic [7:0] wdata;
  } spi_cmd_t;

  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef logic [NUM_DAC-1:0][DAC_W-1:0] dac_bus_t;

endpackage

`default_nettype wire

// ==== src/mhp_reset_stretch.sv ====
/*
  Reset stretcher
  Holds the internal and DAC reset for RST_CYCLES after a soft reset
*/
`timescale 1ns/1ps
`default_nettype none

module mhp_reset_stretch #(
  parameter int RST_CYCLES = 6
) (
  input  wire  ck933,
  input  wire  rs,
  input  wire  soft_rst_i,
  output logic rst_o
);

  localparam int CW = $clog2(RST_CYCLES + 1);

  logic [CW-1:0] cnt_q;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cnt_q <= '0;
      rst_o <= 1'b1;
    end else if (soft_rst_i) begin
      cnt_q <= CW'(RST_CYCLES - 1);  // Pulse cycle counts as the first
      rst_o <= 1'b1;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
      rst_o <= 1'b1;
    end else begin
      rst_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/mhp_top.sv ====
/*
  Demodulator interface top level
  AXI4-Lite registers, reset stretcher, DAC serial port and sample outputs
*/
`timescale 1ns/1ps
`default_nettype none

module mhp_top
  import mhp_pkg::*;
#(
  parameter logic [15:0] VER_NUMBER  = 16'h00aa,
  parameter int          RST_CYCLES  = 6,
  parameter int          CK_DIV_LOG2 = 2
) (
  input  wire                ck933,
  input  wire                rs,
  input  wire axil_req_t     axil_req_i,
  input  wire dac_bus_t      dac_data_i,
  input  wire                dac_sdi_i,
  output axil_rsp_t          axil_rsp_o,
  output dac_bus_t           dac_d_o,
  output logic               dac_sclk_o,
  output logic [NUM_DAC-1:0] dac_ncs_o,
  output logic               dac_sdo_o,
  output logic               dac_soe_o,
  output logic               dac_rst_o
);

  spi_cmd_t           spi_cmd;
  logic               spi_start;
  logic               spi_busy;
  logic [7:0]         spi_rdata;
  logic [NUM_DAC-1:0] dac_en;
  logic               soft_rst;
  logic               int_rst;

  // Register block stays on the external reset
  mhp_axil_regs #(
    .VER_NUMBER (VER_NUMBER)
  ) regs_i (
    .ck933       (ck933),
    .rs          (rs),
    .axil_req_i  (axil_req_i),
    .spi_busy_i  (spi_busy),
    .spi_rdata_i (spi_rdata),
    .axil_rsp_o  (axil_rsp_o),
    .spi_cmd_o   (spi_cmd),
    .spi_start_o (spi_start),
    .dac_en_o    (dac_en),
    .soft_rst_o  (soft_rst)
  );

  mhp_reset_stretch #(
    .RST_CYCLES (RST_CYCLES)
  ) rst_i (
    .ck933      (ck933),
    .rs         (rs),
    .soft_rst_i (soft_rst),
    .rst_o      (int_rst)
  );

  mhp_dac_serial #(
    .CK_DIV_LOG2 (CK_DIV_LOG2)
  ) serial_i (
    .ck933   (ck933),
    .rs      (int_rst),
    .start_i (spi_start),
    .cmd_i   (spi_cmd),
    .sdi_i   (dac_sdi_i),
    .busy_o  (spi_busy),
    .rdata_o (spi_rdata),
    .sclk_o  (dac_sclk_o),
    .ncs_o   (dac_ncs_o),
    .sdo_o   (dac_sdo_o),
    .soe_o   (dac_soe_o)
  );

  mhp_dac_sample_pipe pipe_i (
    .ck933    (ck933),
    .rs       (int_rst),
    .dac_en_i (dac_en),
    .data_i   (dac_data_i),
    .data_o   (dac_d_o)
  );

  assign dac_rst_o = int_rst;  // DAC reset pin follows internal reset

endmodule

`default_nettype wire

// ==== verification/tb_mhp_top.sv ====
/*
  Testbench for the demodulator interface top level
  AXI4-Lite registers, DAC serial slave model, sample pipeline model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mhp_top
  import mhp_pkg::*;
();

  localparam logic [15:0] VER        = 16'h00aa;
  localparam int          WAIT_LIMIT = 200;
  localparam logic [1:0]  OKAY       = 2'b00;
  localparam logic [1:0]  SLVERR     = 2'b10;

  logic               ck933;
  logic               rs;
  axil_req_t          req;
  axil_rsp_t          rsp;
  dac_bus_t           dac_data;
  dac_bus_t           dac_d;
  logic               dac_sclk;
  logic [NUM_DAC-1:0] dac_ncs;
  logic               dac_sdo;
  logic               dac_soe;
  logic               dac_sdi;
  logic               dac_rst;
  integer             seed;
  logic [NUM_DAC-1:0] en_model;   // Last enables written
  logic [NUM_DAC-1:0] cs_expect;  // Chip select pattern of the current frame

  // DAC serial slave state
  logic [7:0]  dac_mem [NUM_DAC][128];
  logic [15:0] frame_bits;
  int          bit_idx;
  int          sel_chan;
  logic        rd_frame;
  logic [7:0]  rd_byte;

  mhp_top #(
    .VER_NUMBER  (VER),
    .RST_CYCLES  (6),
    .CK_DIV_LOG2 (2)
  ) dut_i (
    .ck933      (ck933),
    .rs         (rs),
    .axil_req_i (req),
    .dac_data_i (dac_data),
    .dac_sdi_i  (dac_sdi),
    .axil_rsp_o (rsp),
    .dac_d_o    (dac_d),
    .dac_sclk_o (dac_sclk),
    .dac_ncs_o  (dac_ncs),
    .dac_sdo_o  (dac_sdo),
    .dac_soe_o  (dac_soe),
    .dac_rst_o  (dac_rst)
  );

  initial begin
    ck933 = 1'b0;
    forever #10 ck933 = ~ck933;
  end

  // **************************************************
  // Failure reporting and compare tasks
  // **************************************************
  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_sample(input string name, input dac_bus_t exp, input dac_bus_t got);
    if (got !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  // Offset binary with blanking, per channel
  function automatic dac_bus_t expected_sample(input dac_bus_t raw, input logic [2:0] en);
    dac_bus_t res;
    for (int c = 0; c < NUM_DAC; c++) begin
      res[c] = en[c] ? {~raw[c][DAC_W-1], raw[c][DAC_W-2:0]} : '0;
    end
    return res;
  endfunction

  // **************************************************
  // AXI4-Lite master
  // **************************************************
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    @(posedge ck933);
    #2;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    req.bready  = 1'b1;
    n = 0;
    do begin
      @(negedge ck933);
      n++;
      if (n > WAIT_LIMIT) report_timeout("awready and wready");
    end while (!rsp.awready);
    check_word("wready", 32'h1, 32'(rsp.wready));  // Both ready in the same cycle
    @(posedge ck933);
    #2;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    n = 0;
    do begin
      @(negedge ck933);
      n++;
      if (n > WAIT_LIMIT) report_timeout("bvalid");
    end while (!rsp.bvalid);
    resp = rsp.bresp;
    @(posedge ck933);
    #2;
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(posedge ck933);
    #2;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b1;
    n = 0;
    do begin
      @(negedge ck933);
      n++;
      if (n > WAIT_LIMIT) report_timeout("arready");
    end while (!rsp.arready);
    @(posedge ck933);
    #2;
    req.arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge ck933);
      n++;
      if (n > WAIT_LIMIT) report_timeout("rvalid");
    end while (!rsp.rvalid);
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge ck933);
    #2;
    req.rready = 1'b0;
  endtask

  task automatic set_dac_en(input logic [2:0] en);
    logic [31:0] word;
    logic [1:0]  resp;
    axil_write(REG_DAC_EN, 32'(en), resp);
    check_resp("bresp", OKAY, resp);
    axil_read(REG_DAC_EN, word, resp);
    check_resp("rresp", OKAY, resp);
    check_word("REG_DAC_EN", 32'(en), word);
    en_model = en;
  endtask

  // Polls REG_SPI until busy is clear, returns the last word read
  task automatic poll_spi_idle(output logic [31:0] word);
    logic [1:0] resp;
    int         polls;
    polls = 0;
    do begin
      axil_read(REG_SPI, word, resp);
      check_resp("rresp", OKAY, resp);
      polls++;
      if (polls > WAIT_LIMIT) report_timeout("serial busy to fall");
    end while (word[31]);
  endtask

  task automatic await_dac_rst(input logic level);
    int n;
    n = 0;
    while (dac_rst !== level) begin
      @(negedge ck933);
      n++;
      if (n > WAIT_LIMIT) report_timeout("dac_rst_o to change");
    end
  endtask

  // Random samples, each checked 2 cycles after it is driven
  task automatic run_samples(input int count);
    dac_bus_t raw;
    dac_bus_t exp_q[$];
    for (int i = 0; i < count + 2; i++) begin
      @(posedge ck933);
      #2;
      if (i >= 2) check_sample("dac_d_o", exp_q.pop_front(), dac_d);
      if (i < count) begin
        for (int c = 0; c < NUM_DAC; c++) begin
          raw[c] = DAC_W'(next_random());
        end
        dac_data = raw;
        exp_q.push_back(expected_sample(raw, en_model));
      end
    end
  endtask

  // **************************************************
  // DAC serial slave model
  // **************************************************
  initial begin
    for (int c = 0; c < NUM_DAC; c++) begin
      for (int a = 0; a < 128; a++) begin
        dac_mem[c][a] = 8'((c * 128 + a) * 37 + ((c * 128 + a) >> 8));
      end
    end
    bit_idx  = 0;
    rd_frame = 1'b0;
  end

  always @(dac_ncs) begin
    if (dac_ncs === 3'b111) begin  // Frame over
      bit_idx  = 0;
      rd_frame = 1'b0;
    end
  end

  always @(posedge dac_sclk) begin
    if (dac_ncs !== 3'b111) begin
      case (dac_ncs)
        3'b110:  sel_chan = 0;
        3'b101:  sel_chan = 1;
        3'b011:  sel_chan = 2;
        default: begin
          $display("More than one DAC chip select is low during a frame");
          stop_run();
        end
      endcase
      check_word("dac_soe_o", 32'((bit_idx < 8) || !rd_frame), 32'(dac_soe));
      frame_bits = {frame_bits[14:0], dac_sdo};
      bit_idx    = bit_idx + 1;
      if (bit_idx == 8 && frame_bits[7]) begin
        rd_frame = 1'b1;
        rd_byte  = dac_mem[sel_chan][frame_bits[6:0]];
      end
      if (bit_idx == 16 && !frame_bits[15]) dac_mem[sel_chan][frame_bits[14:8]] = frame_bits[7:0];
    end
  end

  // Read data changes while sclk is low
  always @(negedge dac_sclk) begin
    if (rd_frame && bit_idx >= 8 && bit_idx < 16) dac_sdi <= #2 rd_byte[15 - bit_idx];
  end

  always @(negedge ck933) begin
    if (!rs && dac_ncs !== 3'b111) check_word("dac_ncs_o", 32'(cs_expect), 32'(dac_ncs));
  end

  // **************************************************
  // Test sequence
  // **************************************************
  initial begin : main_flow
    logic [31:0] word;
    logic [1:0]  resp;
    spi_cmd_t    cmd;
    logic [7:0]  exp_byte;
    seed      = 69676;
    req       = '0;
    dac_data  = '0;
    dac_sdi   = 1'b0;
    en_model  = 3'b111;
    cs_expect = 3'b111;
    rs        = 1'b1;
    repeat (16) @(posedge ck933);
    #2;
    rs = 1'b0;

    check_sample("dac_d_o", '0, dac_d);
    check_word("dac_ncs_o", 32'h7, 32'(dac_ncs));
    check_word("dac_sclk_o", 32'h1, 32'(dac_sclk));
    check_word("dac_soe_o", 32'h0, 32'(dac_soe));
    check_word("bvalid", 32'h0, 32'(rsp.bvalid));
    check_word("rvalid", 32'h0, 32'(rsp.rvalid));

    // Register map responses
    axil_read(REG_VERSION, word, resp);
    check_resp("rresp", OKAY, resp);
    check_word("version", 32'(VER), 32'(word[31:16]));
    axil_read(4'h2, word, resp);
    check_resp("rresp", SLVERR, resp);
    axil_read(REG_RESET, word, resp);
    check_resp("rresp", SLVERR, resp);
    axil_write(REG_VERSION, 32'h1234_5678, resp);
    check_resp("bresp", SLVERR, resp);

    run_samples(300);

    for (int k = 0; k < 6; k++) begin
      set_dac_en(3'(next_random()));
      run_samples(20);
    end

    // Serial frames, random direction and channel
    for (int k = 0; k < 16; k++) begin
      word      = next_random();
      cmd.chan  = 2'(word[15:0] % NUM_DAC);
      cmd.rd    = word[16];
      cmd.addr  = word[23:17];
      cmd.wdata = word[31:24];
      exp_byte  = dac_mem[cmd.chan][cmd.addr];
      cs_expect = ~(3'b001 << cmd.chan);
      axil_write(REG_SPI, 32'(cmd), resp);
      check_resp("bresp", OKAY, resp);
      poll_spi_idle(word);
      if (cmd.rd) check_byte("REG_SPI rdata", exp_byte, word[7:0]);
      else        check_byte("dac_mem", cmd.wdata, dac_mem[cmd.chan][cmd.addr]);
    end

    // Soft reset leaves the enables alone
    set_dac_en(3'b010);
    axil_write(REG_RESET, 32'h1, resp);
    check_resp("bresp", OKAY, resp);
    await_dac_rst(1'b1);
    check_sample("dac_d_o", '0, dac_d);
    await_dac_rst(1'b0);
    axil_read(REG_DAC_EN, word, resp);
    check_word("REG_DAC_EN", 32'(en_model), word);
    run_samples(20);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
